// ==== design/dds_pkg.sv ====
package dds_pkg;

  // width of the phase accumulator and of every increment word
  localparam int phase_bits = 16;

  // low phase bits that are dropped before the table lookup
  localparam int quant_bits = 6;

  // address width of a table that would cover the whole circle
  localparam int lut_addr_bits = phase_bits - quant_bits;

  // the stored table covers one quadrant, so two address bits become the quadrant
  localparam int quarter_bits = lut_addr_bits - 2;

  localparam int sample_width = 16;

  // peak value of the cosine, the largest positive sample
  localparam int amplitude = (1 << (sample_width - 1)) - 1;

  // unsigned phase, also used for the increments
  typedef logic [phase_bits-1:0] phase_t;

  // quantized phase, quadrant in the top two bits
  typedef logic [lut_addr_bits-1:0] lut_addr_t;

  // quarter table index, one bit wider than the quadrant offset
  // so that the mirrored index 256 can be reached
  typedef logic [quarter_bits:0] quarter_addr_t;

  // signed two's complement output sample
  typedef logic signed [sample_width-1:0] sample_t;

  // result of the folding stage for one sample lane
  typedef struct packed {
    logic          negate;
    quarter_addr_t index;
  } fold_t;

endpackage

// ==== design/dds_phase_accum.sv ====
`timescale 1ns/1ns

// per-channel phase accumulator producing several sample phases per clock
module dds_phase_accum
  import dds_pkg::*;
#(
  parameter int channels = 2,
  parameter int parallel_samples = 2
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  phase_t [channels-1:0]                       phase_inc,
  input  logic                                        phase_inc_valid,
  output phase_t [channels-1:0][parallel_samples-1:0] phase_out,
  output logic                                        phase_valid
);

  // increment currently in use for each channel
  phase_t [channels-1:0] inc;

  // phase of sample 0 of the next beat
  phase_t [channels-1:0] acc;

  // offset of each lane from the beat base, lane number times the increment
  phase_t [channels-1:0][parallel_samples-1:0] lane_offset;

  // distance the base moves from one beat to the next
  phase_t [channels-1:0] beat_step;

  // the multiplications are by constants, so they reduce to shifts and adds
  always_comb begin
    for (int c = 0; c < channels; c++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        lane_offset[c][s] = phase_t'(s * inc[c]);
      end
      beat_step[c] = phase_t'(parallel_samples * inc[c]);
    end
  end

  // a new increment set is taken whenever the qualifier is high
  // and is first used on the following edge
  always_ff @(posedge clk) begin
    if (reset) begin
      inc <= '0;
    end else if (phase_inc_valid) begin
      inc <= phase_inc;
    end
  end

  // the base advances by one full beat each cycle, wrapping modulo 2^16
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else begin
      for (int c = 0; c < channels; c++) begin
        acc[c] <= acc[c] + beat_step[c];
      end
    end
  end

  // sample phases of the current beat, built from the base before it advances
  always_ff @(posedge clk) begin
    for (int c = 0; c < channels; c++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        phase_out[c][s] <= acc[c] + lane_offset[c][s];
      end
    end
  end

  // the generator never stalls, so a beat leaves on every cycle out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_valid <= 1'b0;
    end else begin
      phase_valid <= 1'b1;
    end
  end

endmodule

// ==== design/dds_phase_fold.sv ====
`timescale 1ns/1ns

// folds each phase onto the quarter-wave table: index plus sign
module dds_phase_fold
  import dds_pkg::*;
#(
  parameter int channels = 2,
  parameter int parallel_samples = 2
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  phase_t [channels-1:0][parallel_samples-1:0] phase_in,
  input  logic                                        phase_valid,
  output fold_t  [channels-1:0][parallel_samples-1:0] fold_out,
  output logic                                        fold_valid
);

  // index of the last table entry, where the cosine reaches zero
  localparam quarter_addr_t quarter_span = quarter_addr_t'(1 << quarter_bits);

  lut_addr_t [channels-1:0][parallel_samples-1:0] lut_addr;
  fold_t     [channels-1:0][parallel_samples-1:0] fold_next;

  // quadrants 1 and 3 read the table backwards from the far end,
  // quadrants 1 and 2 are the half of the circle where the cosine is negative
  always_comb begin
    for (int c = 0; c < channels; c++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        lut_addr[c][s] = phase_in[c][s][phase_bits-1:quant_bits];
        if (lut_addr[c][s][quarter_bits]) begin
          fold_next[c][s].index = quarter_span
                                  - quarter_addr_t'(lut_addr[c][s][quarter_bits-1:0]);
        end else begin
          fold_next[c][s].index = quarter_addr_t'(lut_addr[c][s][quarter_bits-1:0]);
        end
        fold_next[c][s].negate = lut_addr[c][s][lut_addr_bits-1]
                                 ^ lut_addr[c][s][lut_addr_bits-2];
      end
    end
  end

  always_ff @(posedge clk) begin
    fold_out <= fold_next;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fold_valid <= 1'b0;
    end else begin
      fold_valid <= phase_valid;
    end
  end

endmodule

// ==== design/dds_cos_lut.sv ====
`timescale 1ns/1ns

// quarter-wave cosine table with sign restore and output register
module dds_cos_lut
  import dds_pkg::*;
#(
  parameter int channels = 2,
  parameter int parallel_samples = 2
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  fold_t   [channels-1:0][parallel_samples-1:0] fold_in,
  input  logic                                         fold_valid,
  output sample_t [channels-1:0][parallel_samples-1:0] data_out,
  output logic    [channels-1:0]                       data_valid
);

  // one quadrant plus the end point at a quarter turn
  localparam int table_depth = (1 << quarter_bits) + 1;

  localparam real pi = 3.14159265358979323846;

  typedef sample_t table_t [table_depth];

  // entry k holds cos(k * pi / 512) scaled to the peak amplitude,
  // rounded to the nearest integer
  function automatic table_t build_table();
    table_t t;
    real    angle;
    real    scaled;
    for (int k = 0; k < table_depth; k++) begin
      angle = real'(k) * pi / real'(2 << quarter_bits);
      scaled = $cos(angle) * real'(amplitude);
      t[k] = sample_t'($rtoi($floor(scaled + 0.5)));
    end
    return t;
  endfunction

  localparam table_t cos_table = build_table();

  // table value for each lane before the sign is applied
  sample_t [channels-1:0][parallel_samples-1:0] lane_value;

  // signed sample for each lane
  sample_t [channels-1:0][parallel_samples-1:0] lane_sample;

  always_comb begin
    for (int c = 0; c < channels; c++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        lane_value[c][s] = cos_table[fold_in[c][s].index];
        // entries never exceed the amplitude, so negation cannot overflow
        if (fold_in[c][s].negate) begin
          lane_sample[c][s] = -lane_value[c][s];
        end else begin
          lane_sample[c][s] = lane_value[c][s];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    data_out <= lane_sample;
  end

  // every channel moves in lockstep, so one valid is copied to all of them
  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= '0;
    end else begin
      data_valid <= {channels{fold_valid}};
    end
  end

endmodule

// ==== design/dds.sv ====
`timescale 1ns/1ns

// multi-channel DDS: accumulator, quarter-wave fold, cosine lookup
// three registered stages, so a phase reaches data_out two edges after it is formed
module dds
  import dds_pkg::*;
#(
  parameter int channels = 2,
  parameter int parallel_samples = 2
) (
  input  logic                                         clk,
  input  logic                                         reset,
  input  phase_t  [channels-1:0]                       phase_inc,
  input  logic                                         phase_inc_valid,
  output sample_t [channels-1:0][parallel_samples-1:0] data_out,
  output logic    [channels-1:0]                       data_valid
);

  // accumulator to fold stage
  phase_t [channels-1:0][parallel_samples-1:0] phase;
  logic                                        phase_valid;

  // fold stage to lookup
  fold_t [channels-1:0][parallel_samples-1:0] fold;
  logic                                       fold_valid;

  dds_phase_accum #(
    .channels(channels),
    .parallel_samples(parallel_samples)
  ) phase_accum_i (
    .clk(clk),
    .reset(reset),
    .phase_inc(phase_inc),
    .phase_inc_valid(phase_inc_valid),
    .phase_out(phase),
    .phase_valid(phase_valid)
  );

  dds_phase_fold #(
    .channels(channels),
    .parallel_samples(parallel_samples)
  ) phase_fold_i (
    .clk(clk),
    .reset(reset),
    .phase_in(phase),
    .phase_valid(phase_valid),
    .fold_out(fold),
    .fold_valid(fold_valid)
  );

  // output samples are a real-time stream with no back-pressure
  dds_cos_lut #(
    .channels(channels),
    .parallel_samples(parallel_samples)
  ) cos_lut_i (
    .clk(clk),
    .reset(reset),
    .fold_in(fold),
    .fold_valid(fold_valid),
    .data_out(data_out),
    .data_valid(data_valid)
  );

endmodule

// ==== verification/dds_tb.sv ====
`timescale 1ns/1ns

// random-stimulus testbench for the multi-channel DDS with a cycle-accurate model
module dds_tb
  import dds_pkg::*;
();

  localparam int channels = 3;
  localparam int parallel_samples = 4;
  localparam real pi = 3.14159265358979323846;
  localparam int quarter_turn = 1 << (phase_bits - 2);

  logic                                         clk;
  logic                                         reset;
  phase_t  [channels-1:0]                       phase_inc;
  logic                                         phase_inc_valid;
  sample_t [channels-1:0][parallel_samples-1:0] data_out;
  logic    [channels-1:0]                       data_valid;

  // model state holds the increment in use and the base phase of the next beat
  phase_t model_inc [channels];
  phase_t model_acc [channels];

  // stage 0 holds the phase register and stage 2 lines up with data_out
  phase_t     pipe_phase [3][channels][parallel_samples];
  logic [2:0] pipe_valid = '0;

  int error_count = 0;
  int check_count = 0;

  dds #(
    .channels(channels),
    .parallel_samples(parallel_samples)
  ) uut (
    .clk(clk),
    .reset(reset),
    .phase_inc(phase_inc),
    .phase_inc_valid(phase_inc_valid),
    .data_out(data_out),
    .data_valid(data_valid)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // cosine of a phase after quantization, folded onto one quadrant and rounded
  function automatic int expected_sample(input phase_t phase);
    int  addr;
    int  quadrant;
    int  offset;
    int  index;
    int  magnitude;
    real angle;
    addr = int'(phase) >> quant_bits;
    quadrant = addr >> quarter_bits;
    offset = addr & ((1 << quarter_bits) - 1);
    if (quadrant == 1 || quadrant == 3) begin
      index = (1 << quarter_bits) - offset;
    end else begin
      index = offset;
    end
    angle = real'(index) * pi / real'(2 << quarter_bits);
    magnitude = $rtoi($cos(angle) * real'(amplitude) + 0.5);
    if (quadrant == 1 || quadrant == 2) begin
      magnitude = -magnitude;
    end
    return magnitude;
  endfunction

  function automatic phase_t random_increment();
    return phase_t'($urandom);
  endfunction

  // the model reads the inputs as they were just before the edge
  always @(posedge clk) begin
    for (int c = 0; c < channels; c++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        pipe_phase[2][c][s] = pipe_phase[1][c][s];
        pipe_phase[1][c][s] = pipe_phase[0][c][s];
        pipe_phase[0][c][s] = phase_t'(int'(model_acc[c]) + s * int'(model_inc[c]));
      end
    end
    if (reset) begin
      pipe_valid = 3'b000;
    end else begin
      pipe_valid = {pipe_valid[1:0], 1'b1};
    end
    for (int c = 0; c < channels; c++) begin
      if (reset) begin
        model_inc[c] = '0;
        model_acc[c] = '0;
      end else begin
        model_acc[c] = phase_t'(int'(model_acc[c]) + parallel_samples * int'(model_inc[c]));
        if (phase_inc_valid) begin
          model_inc[c] = phase_inc[c];
        end
      end
    end
  end

  // outputs are compared half a period after the edge that produced them
  always @(negedge clk) begin
    int expected;
    int got;
    check_count++;
    if (data_valid !== {channels{pipe_valid[2]}}) begin
      $display("ERROR data_valid got %h expected %h", data_valid, {channels{pipe_valid[2]}});
      error_count++;
    end
    if (pipe_valid[2]) begin
      for (int c = 0; c < channels; c++) begin
        for (int s = 0; s < parallel_samples; s++) begin
          expected = expected_sample(pipe_phase[2][c][s]);
          got = int'(data_out[c][s]);
          check_count++;
          if ($isunknown(data_out[c][s]) || got > expected + 1 || got < expected - 1) begin
            $display("ERROR data_out[%0d][%0d] phase %h got %h expected %h", c, s,
                     pipe_phase[2][c][s], data_out[c][s], sample_t'(expected));
            error_count++;
          end
        end
      end
    end
  end

  // a new increment set is qualified for exactly one cycle
  task automatic load_increments(input phase_t [channels-1:0] value);
    @(posedge clk);
    phase_inc <= value;
    phase_inc_valid <= 1'b1;
    @(posedge clk);
    phase_inc_valid <= 1'b0;
  endtask

  task automatic wait_for_data_valid(input int limit, output int edges);
    bit done;
    edges = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (data_valid === {channels{1'b1}}) begin
        done = 1'b1;
      end else if (edges >= limit) begin
        $display("timeout: data_valid did not rise within %0d cycles after reset", limit);
        error_count++;
        done = 1'b1;
      end
    end
  endtask

  // with no increment loaded the phase stays at zero where the cosine peaks
  task automatic check_idle_amplitude(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      for (int c = 0; c < channels; c++) begin
        for (int s = 0; s < parallel_samples; s++) begin
          check_count++;
          if (data_out[c][s] !== sample_t'(amplitude)) begin
            $display("ERROR data_out[%0d][%0d] got %h expected %h", c, s,
                     data_out[c][s], sample_t'(amplitude));
            error_count++;
          end
        end
      end
    end
  endtask

  initial begin
    int                    edges;
    phase_t [channels-1:0] incs;
    void'($urandom(71009));
    reset = 1'b1;
    phase_inc = '0;
    phase_inc_valid = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    wait_for_data_valid(20, edges);
    if (edges != 3) begin
      $display("data_valid rose %0d edges after reset release instead of 3", edges);
      error_count++;
    end
    check_idle_amplitude(4);

    // steady random increments on every channel
    for (int c = 0; c < channels; c++) begin
      incs[c] = random_increment();
    end
    load_increments(incs);
    repeat (500) @(posedge clk);

    // quarter-turn steps land on the quadrant edges and the mirrored index 256
    for (int k = 0; k < 9; k++) begin
      for (int c = 0; c < channels; c++) begin
        incs[c] = phase_t'(quarter_turn * ((k + c) % 3 + 1));
        if (k >= 3) begin
          incs[c] = phase_t'(int'(incs[c]) + int'($urandom % 193) - 96);
        end
      end
      load_increments(incs);
      repeat (24) @(posedge clk);
    end

    // increment changes at random moments
    repeat (25) begin
      repeat (1 + $urandom % 16) @(posedge clk);
      for (int c = 0; c < channels; c++) begin
        incs[c] = random_increment();
      end
      load_increments(incs);
    end

    // zero, full-scale and random increments side by side
    for (int r = 0; r < 6; r++) begin
      for (int c = 0; c < channels; c++) begin
        case ((c + r) % 3)
          0: incs[c] = '0;
          1: incs[c] = 16'hffff;
          default: incs[c] = random_increment();
        endcase
      end
      load_increments(incs);
      repeat (60) @(posedge clk);
    end

    // let the beats still in flight reach the output and be compared
    repeat (4) @(posedge clk);
    $display("errors: %0d, checks: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== dds.f ====
design/dds_pkg.sv
design/dds_phase_accum.sv
design/dds_phase_fold.sv
design/dds_cos_lut.sv
design/dds.sv
verification/dds_tb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the DDS

VERILATOR  ?= verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only -Wall
TOP        = dds_tb
RTL_TOP    = dds
FILELIST   = dds.f
OBJ_DIR    = obj_dir
LOG        = run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, since the simulator exits cleanly either way
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
